//--- filelist.f
+incdir+source
source/ghrd_pkg.sv
source/key_debouncer.sv
source/reset_pulse_stretcher.sv
source/heartbeat_blinker.sv
source/ghrd_fabric_top.sv
test/tb_clock_gen.sv
test/tb_ghrd_fabric_top.sv

//--- source/ghrd_cfg.svh
// ==========================================================================
// board fabric configuration
// key and switch counts, debounce time, reset request pulse lengths and
// the heartbeat half period, all in fpga_clk_50 cycles (50 MHz)
// ==========================================================================

`ifndef GHRD_CFG_SVH
`define GHRD_CFG_SVH

// --------------------------------------------------------------------------
// board i/o counts
// --------------------------------------------------------------------------
`define GHRD_KEY_COUNT          2         // push keys, active low
`define GHRD_SW_COUNT           4         // dip switches

// --------------------------------------------------------------------------
// key filter
// --------------------------------------------------------------------------
`define GHRD_DEBOUNCE_CYCLES    50000     // 1 ms at 50 MHz

// --------------------------------------------------------------------------
// hps reset request pulse lengths
// --------------------------------------------------------------------------
`define GHRD_COLD_STRETCH       6         // cold reset request
`define GHRD_WARM_STRETCH       2         // warm reset request
`define GHRD_DEBUG_STRETCH      32        // debug reset request

// --------------------------------------------------------------------------
// heartbeat
// --------------------------------------------------------------------------
// 0.5 s high, 0.5 s low -> 1 Hz blink
`define GHRD_BLINK_HALF_PERIOD  25000000

`endif

//--- source/ghrd_fabric_top.sv
// ==========================================================================
// board fabric top level
// key debouncing, hps cold / warm / debug reset request pulses, the
// heartbeat led and the stm hw event word around the processor system
// ==========================================================================

`timescale 1ns/1ps

`include "ghrd_cfg.svh"

module ghrd_fabric_top
#(
  parameter int debounce_cycles   = `GHRD_DEBOUNCE_CYCLES,
  parameter int cold_stretch      = `GHRD_COLD_STRETCH,
  parameter int warm_stretch      = `GHRD_WARM_STRETCH,
  parameter int debug_stretch     = `GHRD_DEBUG_STRETCH,
  parameter int blink_half_period = `GHRD_BLINK_HALF_PERIOD
)
(
  input  logic                 fpga_clk_50,
  input  logic                 hps_fpga_reset_n,   // h2f reset from the hps

  // board i/o
  input  ghrd_pkg::key_t       key,                // push keys, active low
  input  ghrd_pkg::switch_t    sw,                 // dip switches
  output ghrd_pkg::led_t       led,

  // processor side
  input  ghrd_pkg::led_pio_t   led_pio,            // led pio export
  input  ghrd_pkg::reset_req_t reset_req,          // {debug, warm, cold}
  output ghrd_pkg::key_t       keys_clean,         // to the button pio
  output logic                 cold_reset_req_n,
  output logic                 warm_reset_req_n,
  output logic                 debug_reset_req_n,
  output ghrd_pkg::hw_events_t hw_events           // stm trace events
);

  // zero padding on top of the event word
  localparam int pad_w = $bits(ghrd_pkg::hw_events_t) - $bits(ghrd_pkg::switch_t)
                         - $bits(ghrd_pkg::led_pio_t) - $bits(ghrd_pkg::key_t);

  logic heartbeat;

  // ========================================================================
  // key debounce
  // ========================================================================
  key_debouncer
  #(
    .key_count       (`GHRD_KEY_COUNT),
    .debounce_cycles (debounce_cycles)
  )
  u_key_debouncer
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_clean        (keys_clean)
  );

  // ========================================================================
  // hps reset requests, one stretcher per line
  // ========================================================================
  reset_pulse_stretcher #(.stretch_cycles(cold_stretch)) u_cold_stretch
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req[0]),   // cold
    .reset_req_n      (cold_reset_req_n)
  );

  reset_pulse_stretcher #(.stretch_cycles(warm_stretch)) u_warm_stretch
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req[1]),   // warm
    .reset_req_n      (warm_reset_req_n)
  );

  reset_pulse_stretcher #(.stretch_cycles(debug_stretch)) u_debug_stretch
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req[2]),   // debug
    .reset_req_n      (debug_reset_req_n)
  );

  // ========================================================================
  // heartbeat
  // ========================================================================
  heartbeat_blinker #(.half_period(blink_half_period)) u_heartbeat
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .heartbeat        (heartbeat)
  );

  // ========================================================================
  // output packing
  // ========================================================================
  assign led = {led_pio, heartbeat};   // pio bits on top, heartbeat on bit 0

  // {zeros, switches, led pio, debounced keys}
  assign hw_events = {{pad_w{1'b0}}, sw, led_pio, keys_clean};

endmodule

//--- source/ghrd_pkg.sv
// ==========================================================================
// board fabric types
// vector types for keys, switches, leds, the trace event word and the
// reset request lines, plus the reset pulse stretcher state encoding
// ==========================================================================

`include "ghrd_cfg.svh"

package ghrd_pkg;

  // ========================================================================
  // board i/o vectors
  // ========================================================================
  typedef logic [`GHRD_KEY_COUNT-1:0] key_t;    // raw or debounced keys
  typedef logic [`GHRD_SW_COUNT-1:0]  switch_t; // dip switches

  // led bits driven by the processor pio
  typedef logic [6:0] led_pio_t;

  // board leds, bit 0 heartbeat, bits 7..1 from led_pio_t
  typedef logic [7:0] led_t;

  // ========================================================================
  // hps side vectors
  // ========================================================================
  // stm trace hw event word
  // {15 zeros, switches, led pio, debounced keys}
  typedef logic [27:0] hw_events_t;

  // reset request lines, bit 0 cold, bit 1 warm, bit 2 debug
  typedef logic [2:0] reset_req_t;

  // ========================================================================
  // reset pulse stretcher fsm
  // ========================================================================
  typedef enum logic
  {
    st_idle,        // waiting for a rising request edge
    st_stretching   // holding the request output low
  } stretch_state_e;

endpackage

//--- source/heartbeat_blinker.sv
// ==========================================================================
// heartbeat blinker
// free running counter that toggles the heartbeat led every half_period
// clocks, 1 Hz at 50 MHz with the default half period
// ==========================================================================

`timescale 1ns/1ps

`include "ghrd_cfg.svh"

module heartbeat_blinker
#(
  parameter int half_period = `GHRD_BLINK_HALF_PERIOD   // clocks per level
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic heartbeat        // drives led bit 0
);

  // counter runs 0 .. half_period-1
  localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half_period - 1);

  logic [cnt_w-1:0] cnt;

  // ========================================================================
  // counter and toggle
  // ========================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt       <= '0;
      heartbeat <= 1'b0;          // led off out of reset
    end
    else if (cnt == cnt_last)
    begin
      cnt       <= '0;            // wrap
      heartbeat <= ~heartbeat;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- source/key_debouncer.sv
// ==========================================================================
// push key debouncer
// per key stable time filter, the clean level follows the raw level only
// after the raw level has held its new value for debounce_cycles clocks
// ==========================================================================

`timescale 1ns/1ps

`include "ghrd_cfg.svh"

module key_debouncer
#(
  parameter int key_count       = `GHRD_KEY_COUNT,        // keys to filter
  parameter int debounce_cycles = `GHRD_DEBOUNCE_CYCLES   // hold time, clocks
)
(
  input  logic           fpga_clk_50,
  input  logic           hps_fpga_reset_n,
  input  ghrd_pkg::key_t key_raw,     // straight from the key pins
  output ghrd_pkg::key_t key_clean    // filtered, idle high
);

  // ========================================================================
  // counter sizing
  // ========================================================================
  // counter runs 0 .. debounce_cycles-1, flip happens on the last count
  localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

  // ========================================================================
  // one filter per key
  // ========================================================================
  genvar i;
  generate
    for (i = 0; i < key_count; i++)
    begin : g_key
      logic [cnt_w-1:0] cnt;      // consecutive disagreeing samples
      logic             clean_q;  // filtered level of this key
      logic             differ;   // raw level disagrees with clean level

      assign differ = key_raw[i] ^ clean_q;

      always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
      begin
        if (!hps_fpga_reset_n)
        begin
          cnt     <= '0;
          clean_q <= 1'b1;          // keys are active low, released = 1
        end
        else if (!differ)
        begin
          cnt <= '0;                // any agreement restarts the count
        end
        else if (cnt == cnt_last)
        begin
          // raw level held for the full window, accept it
          cnt     <= '0;
          clean_q <= key_raw[i];
        end
        else
        begin
          cnt <= cnt + 1'b1;        // still bouncing or still holding
        end
      end

      assign key_clean[i] = clean_q;
    end
  endgenerate

endmodule

//--- source/reset_pulse_stretcher.sv
// ==========================================================================
// reset request pulse stretcher
// a rising edge on the request line gives an active low reset request of
// exactly stretch_cycles clocks, new edges are ignored while it is busy
// ==========================================================================

`timescale 1ns/1ps

`include "ghrd_cfg.svh"

module reset_pulse_stretcher
#(
  parameter int stretch_cycles = `GHRD_COLD_STRETCH   // low time, clocks
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic request,       // level request, active high
  output logic reset_req_n    // stretched request to the hps, active low
);

  // ========================================================================
  // counter sizing
  // ========================================================================
  localparam int cnt_w = (stretch_cycles > 1) ? $clog2(stretch_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(stretch_cycles - 1);

  ghrd_pkg::stretch_state_e state;
  logic                     request_q;  // request one clock ago
  logic                     req_rise;   // 0 -> 1 on the request line
  logic [cnt_w-1:0]         cnt;        // cycles spent stretching

  // ========================================================================
  // edge detect
  // ========================================================================
  assign req_rise = request & ~request_q;

  // held at 1 in reset so a request line already high when the hps
  // releases reset does not fire another reset request straight away
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      request_q <= 1'b1;
    else
      request_q <= request;
  end

  // ========================================================================
  // stretch fsm
  // ========================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state <= ghrd_pkg::st_idle;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        ghrd_pkg::st_idle:
        begin
          if (req_rise)
          begin
            state <= ghrd_pkg::st_stretching;
            cnt   <= '0;
          end
        end
        ghrd_pkg::st_stretching:
        begin
          // request line not looked at in here
          if (cnt == cnt_last)
          begin
            state <= ghrd_pkg::st_idle;
            cnt   <= '0;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        default:
        begin
          state <= ghrd_pkg::st_idle;
        end
      endcase
    end
  end

  // registered output, trails the fsm by one clock
  // low for exactly the stretch_cycles clocks that the fsm is busy
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      reset_req_n <= 1'b1;                          // no request out of reset
    else
      reset_req_n <= (state == ghrd_pkg::st_idle);
  end

endmodule

//--- test/tb_clock_gen.sv
// ==========================================================================
// testbench clock and reset source
// free running fpga_clk_50 and a power-on reset held for reset_cycles
// ==========================================================================

`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter int period_ns    = 20,  // 50 MHz
  parameter int reset_cycles = 8
)
(
  output logic fpga_clk_50,
  output logic hps_fpga_reset_n
);

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #(period_ns / 2) fpga_clk_50 = ~fpga_clk_50;
  end

  initial
  begin
    hps_fpga_reset_n = 1'b0;
    repeat (reset_cycles) @(posedge fpga_clk_50);
    @(negedge fpga_clk_50);         // release away from the rising edge
    hps_fpga_reset_n = 1'b1;
  end

endmodule

//--- test/tb_ghrd_fabric_top.sv
// ==========================================================================
// board fabric testbench
// table driven checks of key debouncing, event word and led packing,
// reset request pulse lengths and the heartbeat period
// ==========================================================================

`timescale 1ns/1ps

module tb_ghrd_fabric_top;

  localparam int clk_period  = 20;
  localparam int reset_len   = 8;
  localparam int debounce_t  = 16;  // shortened filter window
  localparam int half_t      = 40;  // shortened blink half period
  localparam int max_entries = 24;

  typedef enum int
  {
    op_idle, op_glitch, op_key, op_events, op_pulse, op_pulse_reedge, op_heartbeat
  } op_e;

  logic                 fpga_clk_50;
  logic                 hps_fpga_reset_n;
  ghrd_pkg::key_t       key;
  ghrd_pkg::switch_t    sw;
  ghrd_pkg::led_pio_t   led_pio;
  ghrd_pkg::reset_req_t reset_req;
  ghrd_pkg::led_t       led;
  ghrd_pkg::key_t       keys_clean;
  logic                 cold_reset_req_n;
  logic                 warm_reset_req_n;
  logic                 debug_reset_req_n;
  ghrd_pkg::hw_events_t hw_events;

  // ========================================================================
  // stimulus table as one array per column
  // ========================================================================
  op_e                  op_tab   [max_entries];
  string                name_tab [max_entries];
  ghrd_pkg::key_t       key_tab  [max_entries];
  ghrd_pkg::switch_t    sw_tab   [max_entries];
  ghrd_pkg::led_pio_t   pio_tab  [max_entries];
  ghrd_pkg::reset_req_t req_tab  [max_entries];
  int                   hold_tab [max_entries];  // cycles the stimulus lasts
  logic [31:0]          exp_tab  [max_entries];
  int                   n_entries   = 0;
  bit                   table_ready = 1'b0;
  integer               seed        = 55201;
  ghrd_pkg::key_t       key_model;               // expected keys_clean

  tb_clock_gen #(.period_ns(clk_period), .reset_cycles(reset_len)) u_clock_gen
  (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n)
  );

  ghrd_fabric_top
  #(
    .debounce_cycles   (debounce_t),
    .cold_stretch      (6),
    .warm_stretch      (2),
    .debug_stretch     (32),
    .blink_half_period (half_t)
  )
  dut0
  (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led               (led),
    .led_pio           (led_pio),
    .reset_req         (reset_req),
    .keys_clean        (keys_clean),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .hw_events         (hw_events)
  );

  // ========================================================================
  // failure reporting and compares
  // ========================================================================
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_keys(input string name, input ghrd_pkg::key_t expected,
                            input ghrd_pkg::key_t actual);
    if (actual !== expected)
      report_failure($sformatf("ERR %s: expected %b actual %b", name, expected, actual));
  endtask

  task automatic check_events(input string name, input ghrd_pkg::hw_events_t expected,
                              input ghrd_pkg::hw_events_t actual);
    if (actual !== expected)
      report_failure($sformatf("ERR %s: expected %h actual %h", name, expected, actual));
  endtask

  // only the bits set in mask are compared
  task automatic check_led(input string name, input ghrd_pkg::led_t expected,
                           input ghrd_pkg::led_t actual, input ghrd_pkg::led_t mask);
    if ((actual & mask) !== (expected & mask))
      report_failure($sformatf("ERR %s: expected %b actual %b", name,
                               expected & mask, actual & mask));
  endtask

  task automatic check_req_lines(input string name, input ghrd_pkg::reset_req_t expected,
                                 input ghrd_pkg::reset_req_t actual);
    if (actual !== expected)
      report_failure($sformatf("ERR %s: expected %b actual %b", name, expected, actual));
  endtask

  task automatic check_pulse_len(input string name, input int expected, input int actual);
    if (actual != expected)
      report_failure($sformatf("ERR %s: expected %0d actual %0d", name, expected, actual));
  endtask

  // selected request output low for a one-hot sel of {debug, warm, cold}
  function automatic bit req_low(input ghrd_pkg::reset_req_t sel);
    return ({debug_reset_req_n, warm_reset_req_n, cold_reset_req_n} & sel) == 3'b000;
  endfunction

  // ========================================================================
  // table build
  // ========================================================================
  task automatic add_entry(input op_e op, input string name, input ghrd_pkg::key_t k,
                           input ghrd_pkg::switch_t s, input ghrd_pkg::led_pio_t p,
                           input ghrd_pkg::reset_req_t r, input int hold,
                           input logic [31:0] expected);
    op_tab[n_entries]   = op;
    name_tab[n_entries] = name;
    key_tab[n_entries]  = k;
    sw_tab[n_entries]   = s;
    pio_tab[n_entries]  = p;
    req_tab[n_entries]  = r;
    hold_tab[n_entries] = hold;
    exp_tab[n_entries]  = expected;
    n_entries++;
  endtask

  task automatic build_table();
    ghrd_pkg::switch_t  s;
    ghrd_pkg::led_pio_t p;
    add_entry(op_idle,   "reset_idle",     2'b11, '0, '0, '0, 1, 32'h3);
    add_entry(op_glitch, "key0_short",     2'b10, '0, '0, '0, debounce_t - 1, 32'h3);
    add_entry(op_key,    "key0_press",     2'b10, '0, '0, '0, debounce_t, 32'h2);
    for (int i = 0; i < 5; i++)
    begin
      s = ghrd_pkg::switch_t'($random(seed));
      p = ghrd_pkg::led_pio_t'($random(seed));
      // raw keys flipped for one cycle while the debounced field stays 2'b10
      add_entry(op_events, $sformatf("events_%0d", i), 2'b01, s, p, '0, 1,
                32'({15'b0, s, p, 2'b10}));
    end
    add_entry(op_key,    "key1_press",     2'b00, '0, '0, '0, debounce_t, 32'h0);
    add_entry(op_glitch, "keys_bounce",    2'b11, '0, '0, '0, debounce_t - 1, 32'h0);
    add_entry(op_key,    "keys_release",   2'b11, '0, '0, '0, debounce_t, 32'h3);
    add_entry(op_pulse,        "cold_pulse",  '1, '0, '0, 3'b001, 6 + 12, 6);
    add_entry(op_pulse,        "warm_pulse",  '1, '0, '0, 3'b010, 2 + 12, 2);
    add_entry(op_pulse,        "debug_pulse", '1, '0, '0, 3'b100, 32 + 12, 32);
    add_entry(op_pulse_reedge, "debug_retrig", '1, '0, '0, 3'b100, 32 + 12, 32);
    add_entry(op_heartbeat,    "heartbeat_a", '1, '0, '0, '0, 3 * half_t, half_t);
    add_entry(op_heartbeat,    "heartbeat_b", '1, '0, '0, '0, 3 * half_t, half_t);
  endtask

  // ========================================================================
  // per operation drivers
  // ========================================================================
  task automatic run_idle(input int i);
    @(negedge fpga_clk_50);
    check_keys(name_tab[i], ghrd_pkg::key_t'(exp_tab[i]), keys_clean);
    check_req_lines(name_tab[i], 3'b111,
                    {debug_reset_req_n, warm_reset_req_n, cold_reset_req_n});
    check_led(name_tab[i], 8'h00, led, 8'h01);    // heartbeat off
  endtask

  // key changed for hold cycles then restored while the clean level holds
  task automatic run_glitch(input int i);
    @(posedge fpga_clk_50);
    key <= key_tab[i];
    repeat (hold_tab[i]) @(posedge fpga_clk_50);
    key <= key_model;
    repeat (debounce_t + 4)
    begin
      @(negedge fpga_clk_50);
      check_keys(name_tab[i], ghrd_pkg::key_t'(exp_tab[i]), keys_clean);
    end
  endtask

  // old level up to the last window edge and the new level right after it
  task automatic run_key(input int i);
    @(posedge fpga_clk_50);
    key <= key_tab[i];
    repeat (hold_tab[i] - 1) @(posedge fpga_clk_50);
    @(negedge fpga_clk_50);
    check_keys({name_tab[i], "_early"}, key_model, keys_clean);
    @(negedge fpga_clk_50);
    check_keys(name_tab[i], ghrd_pkg::key_t'(exp_tab[i]), keys_clean);
    key_model = ghrd_pkg::key_t'(exp_tab[i]);
  endtask

  // raw keys last one cycle so the debounced field keeps its level
  task automatic run_events(input int i);
    @(posedge fpga_clk_50);
    key     <= key_tab[i];
    sw      <= sw_tab[i];
    led_pio <= pio_tab[i];
    @(negedge fpga_clk_50);
    check_events(name_tab[i], ghrd_pkg::hw_events_t'(exp_tab[i]), hw_events);
    check_led(name_tab[i], {pio_tab[i], 1'b0}, led, 8'hfe);
    @(posedge fpga_clk_50);
    key <= key_model;
  endtask

  // one cycle request then a count of low cycles on the selected output
  task automatic run_pulse(input int i, input bit reedge);
    int len;
    int waited;
    len    = 0;
    waited = 0;
    @(posedge fpga_clk_50);
    reset_req <= req_tab[i];
    @(posedge fpga_clk_50);
    reset_req <= '0;
    @(negedge fpga_clk_50);
    while (!req_low(req_tab[i]))
    begin
      waited++;
      if (waited > 8)
        report_failure($sformatf("%s: reset request output never went low", name_tab[i]));
      @(negedge fpga_clk_50);
    end
    while (req_low(req_tab[i]))
    begin
      len++;
      if (len > 2 * int'(exp_tab[i]) + 8)
        report_failure($sformatf("%s: reset request output stuck low", name_tab[i]));
      @(posedge fpga_clk_50);
      reset_req <= (reedge && len == 4) ? req_tab[i] : 3'b000;  // edge mid pulse
      @(negedge fpga_clk_50);
    end
    check_pulse_len(name_tab[i], int'(exp_tab[i]), len);
  endtask

  // spacing between two heartbeat toggles
  task automatic run_heartbeat(input int i);
    logic hb;
    int   n;
    int   len;
    n   = 0;
    len = 0;
    @(negedge fpga_clk_50);
    hb = led[0];
    while (led[0] === hb)
    begin
      n++;
      if (n > 2 * half_t + 4)
        report_failure($sformatf("%s: heartbeat never toggled", name_tab[i]));
      @(negedge fpga_clk_50);
    end
    hb = led[0];
    while (led[0] === hb)
    begin
      len++;
      if (len > 2 * half_t + 4)
        report_failure($sformatf("%s: heartbeat stopped toggling", name_tab[i]));
      @(negedge fpga_clk_50);
    end
    check_pulse_len(name_tab[i], int'(exp_tab[i]), len);
  endtask

  // ========================================================================
  // main sequence
  // ========================================================================
  initial
  begin
    key       = '1;      // keys released
    sw        = '0;
    led_pio   = '0;
    reset_req = '0;
    key_model = '1;
    build_table();
    table_ready = 1'b1;
    wait (hps_fpga_reset_n === 1'b1);
    for (int i = 0; i < n_entries; i++)
    begin
      case (op_tab[i])
        op_idle:         run_idle(i);
        op_glitch:       run_glitch(i);
        op_key:          run_key(i);
        op_events:       run_events(i);
        op_pulse:        run_pulse(i, 1'b0);
        op_pulse_reedge: run_pulse(i, 1'b1);
        op_heartbeat:    run_heartbeat(i);
        default:         report_failure("unknown table operation");
      endcase
    end
    $display("All tests passed!");
    $finish;
  end

  // watchdog limit scales with the table hold lengths
  initial
  begin
    int limit;
    limit = 0;
    wait (table_ready);
    for (int i = 0; i < n_entries; i++)
      limit += hold_tab[i];
    limit = 2 * limit + reset_len + 200;
    #(limit * clk_period);
    report_failure($sformatf("watchdog: run did not finish within %0d clock cycles", limit));
  end

endmodule
